//--- hdl/line_code_pkg.sv
`default_nettype none

package line_code_pkg;

	//////////////////////////////////////////////////////////////////////
	// Widths
	//////////////////////////////////////////////////////////////////////

	localparam int data_width   = 8;
	localparam int symbol_width = 10;
	localparam int sub6_width   = 6;
	localparam int sub4_width   = 4;

	// Longest legal run of equal bits on the line
	localparam int run_limit = 5;

	//////////////////////////////////////////////////////////////////////
	// Types
	//////////////////////////////////////////////////////////////////////

	typedef logic [data_width-1:0]   data_byte_t;
	typedef logic [symbol_width-1:0] symbol_t;
	typedef logic [sub6_width-1:0]   sub6_t;
	typedef logic [sub4_width-1:0]   sub4_t;

	//////////////////////////////////////////////////////////////////////
	// Code constants
	//////////////////////////////////////////////////////////////////////

	// K28 family, five-bit field
	localparam logic [4:0] k28_index = 5'd28;

	// K28 first sub-block in negative form
	localparam sub6_t k28_sub6 = 6'b001111;

	// Seven-bit comma patterns, abcdeif order
	localparam logic [6:0] comma_plus  = 7'b0011111;
	localparam logic [6:0] comma_minus = 7'b1100000;

endpackage

`default_nettype wire

//--- hdl/code_group_if.sv
`timescale 1ns/1ns
`default_nettype none

interface code_group_if import line_code_pkg::*; ();

	logic  valid;
	logic  code_error;
	sub6_t sub6;
	logic  flip6;
	sub4_t sub4;
	sub4_t sub4_alt;
	logic  alt_if_neg;
	logic  alt_if_pos;
	logic  flip4;

	modport drive (
		output valid, code_error, sub6, flip6,
		output sub4, sub4_alt, alt_if_neg, alt_if_pos, flip4
	);

	modport accept (
		input valid, code_error, sub6, flip6,
		input sub4, sub4_alt, alt_if_neg, alt_if_pos, flip4
	);

endinterface

`default_nettype wire

//--- hdl/encode_5b6b.sv
`timescale 1ns/1ns
`default_nettype none

module encode_5b6b import line_code_pkg::*; (
	input  logic [4:0] value,
	output sub6_t      code,
	output logic       flip
);

	// Negative-disparity form, abcdei with a in the MSB
	always_comb begin
		case (value)
			5'd0:  code = 6'b100111;
			5'd1:  code = 6'b011101;
			5'd2:  code = 6'b101101;
			5'd3:  code = 6'b110001;
			5'd4:  code = 6'b110101;
			5'd5:  code = 6'b101001;
			5'd6:  code = 6'b011001;
			5'd7:  code = 6'b111000;
			5'd8:  code = 6'b111001;
			5'd9:  code = 6'b100101;
			5'd10: code = 6'b010101;
			5'd11: code = 6'b110100;
			5'd12: code = 6'b001101;
			5'd13: code = 6'b101100;
			5'd14: code = 6'b011100;
			5'd15: code = 6'b010111;
			5'd16: code = 6'b011011;
			5'd17: code = 6'b100011;
			5'd18: code = 6'b010011;
			5'd19: code = 6'b110010;
			5'd20: code = 6'b001011;
			5'd21: code = 6'b101010;
			5'd22: code = 6'b011010;
			5'd23: code = 6'b111010;
			5'd24: code = 6'b110011;
			5'd25: code = 6'b100110;
			5'd26: code = 6'b010110;
			5'd27: code = 6'b110110;
			5'd28: code = 6'b001110;
			5'd29: code = 6'b101110;
			5'd30: code = 6'b011110;
			5'd31: code = 6'b101011;
		endcase
	end

	// D.7 is balanced but still swaps to 000111 under positive disparity
	assign flip = (value == 5'd7);

endmodule

`default_nettype wire

//--- hdl/encode_3b4b.sv
`timescale 1ns/1ns
`default_nettype none

module encode_3b4b import line_code_pkg::*; (
	input  logic [2:0] value,
	output sub4_t      code,
	output sub4_t      code_alt,
	output logic       flip
);

	// Negative-disparity form, fghj with f in the MSB
	always_comb begin
		case (value)
			3'd0: code = 4'b1011;
			3'd1: code = 4'b1001;
			3'd2: code = 4'b0101;
			3'd3: code = 4'b1100;
			3'd4: code = 4'b1101;
			3'd5: code = 4'b1010;
			3'd6: code = 4'b0110;
			3'd7: code = 4'b1110;
		endcase
	end

	// A7 replaces P7 to break up long runs after some 6b codes
	always_comb begin
		code_alt = code;
		if (value == 3'd7) begin
			code_alt = 4'b0111;
		end
	end

	// x.3 is balanced yet alternates with disparity
	assign flip = (value == 3'd3);

endmodule

`default_nettype wire

//--- hdl/code_group_decode.sv
`timescale 1ns/1ns
`default_nettype none

module code_group_decode import line_code_pkg::*; (
	input  logic        pclk,
	input  logic        reset,
	input  logic        enable,
	input  logic        tx_data_k,
	input  data_byte_t  data,
	code_group_if.drive grp
);

	logic [4:0] low5;
	logic [2:0] high3;
	sub6_t      tab6;
	logic       tab6_flip;
	sub4_t      tab4;
	sub4_t      tab4_alt;
	logic       tab4_flip;

	logic       is_k28;
	logic       is_k_alt;
	logic       k_legal;
	logic       x7;
	logic       bal4;
	logic       plain;

	assign low5  = data[4:0];
	assign high3 = data[7:5];

	encode_5b6b u_5b6b (
		.value (low5),
		.code  (tab6),
		.flip  (tab6_flip)
	);

	encode_3b4b u_3b4b (
		.value    (high3),
		.code     (tab4),
		.code_alt (tab4_alt),
		.flip     (tab4_flip)
	);

	//////////////////////////////////////////////////////////////////////
	// Control symbol checks
	//////////////////////////////////////////////////////////////////////

	assign x7       = (high3 == 3'd7);
	assign is_k28   = tx_data_k && (low5 == k28_index);
	assign is_k_alt = tx_data_k && x7 && (low5 inside {5'd23, 5'd27, 5'd29, 5'd30});
	assign k_legal  = is_k28 || is_k_alt;
	// Illegal K falls back to the data code
	assign plain    = !k_legal;
	assign bal4     = ($countones(tab4) == 2);

	always_ff @(posedge pclk) begin
		if (reset) begin
			grp.valid      <= 1'b0;
			grp.code_error <= 1'b0;
		end else begin
			grp.valid      <= enable;
			grp.code_error <= enable && tx_data_k && !k_legal;
		end
	end

	always_ff @(posedge pclk) begin
		if (enable) begin
			grp.sub6     <= is_k28 ? k28_sub6 : tab6;
			grp.flip6    <= is_k28 || tab6_flip;
			// After K28 the balanced codes run opposite to the data rule
			grp.sub4     <= (is_k28 && bal4 && !tab4_flip) ? ~tab4 : tab4;
			grp.flip4    <= tab4_flip || (is_k28 && bal4);
			grp.sub4_alt <= tab4_alt;
			grp.alt_if_neg <= (k_legal && x7) ||
				(plain && x7 && (low5 inside {5'd17, 5'd18, 5'd20}));
			grp.alt_if_pos <= (k_legal && x7) ||
				(plain && x7 && (low5 inside {5'd11, 5'd13, 5'd14}));
		end
	end

endmodule

`default_nettype wire

//--- hdl/disparity_control.sv
`timescale 1ns/1ns
`default_nettype none

module disparity_control import line_code_pkg::*; (
	input  logic         pclk,
	input  logic         reset,
	code_group_if.accept grp,
	output symbol_t      symbol,
	output logic         symbol_valid,
	output logic         code_error
);

	// High when running disparity is positive
	logic  rd;

	logic  bal6;
	logic  comp6;
	sub6_t code6;
	logic  rd_mid;

	logic  use_alt;
	sub4_t pick4;
	logic  bal4;
	logic  comp4;
	sub4_t code4;
	logic  rd_next;

	//////////////////////////////////////////////////////////////////////
	// First sub-block
	//////////////////////////////////////////////////////////////////////

	assign bal6   = ($countones(grp.sub6) == 3);
	assign comp6  = rd && (!bal6 || grp.flip6);
	assign code6  = comp6 ? ~grp.sub6 : grp.sub6;
	assign rd_mid = rd ^ !bal6;

	//////////////////////////////////////////////////////////////////////
	// Second sub-block
	//////////////////////////////////////////////////////////////////////

	assign use_alt = rd_mid ? grp.alt_if_pos : grp.alt_if_neg;
	assign pick4   = use_alt ? grp.sub4_alt : grp.sub4;
	assign bal4    = ($countones(pick4) == 2);
	assign comp4   = rd_mid && (!bal4 || grp.flip4);
	assign code4   = comp4 ? ~pick4 : pick4;
	assign rd_next = rd_mid ^ !bal4;

	always_ff @(posedge pclk) begin
		if (reset) begin
			rd           <= 1'b0;
			symbol_valid <= 1'b0;
			code_error   <= 1'b0;
		end else begin
			symbol_valid <= grp.valid;
			code_error   <= grp.valid && grp.code_error;
			// Idle cycles hold disparity
			if (grp.valid) begin
				rd <= rd_next;
			end
		end
	end

	// 6b block in the high bits goes out first
	always_ff @(posedge pclk) begin
		if (grp.valid) begin
			symbol <= {code6, code4};
		end
	end

endmodule

`default_nettype wire

//--- hdl/encoder_8b10b.sv
`timescale 1ns/1ns
`default_nettype none

module encoder_8b10b import line_code_pkg::*; (
	input  logic       pclk,
	input  logic       reset,
	input  logic       enable,
	input  logic       tx_data_k,
	input  data_byte_t data,
	output symbol_t    symbol,
	output logic       symbol_valid,
	output logic       code_error
);

	//////////////////////////////////////////////////////////////////////
	// Decode to disparity control
	//////////////////////////////////////////////////////////////////////

	code_group_if grp ();

	code_group_decode u_decode (
		.pclk      (pclk),
		.reset     (reset),
		.enable    (enable),
		.tx_data_k (tx_data_k),
		.data      (data),
		.grp       (grp.drive)
	);

	// Running disparity and output register
	disparity_control u_disparity (
		.pclk         (pclk),
		.reset        (reset),
		.grp          (grp.accept),
		.symbol       (symbol),
		.symbol_valid (symbol_valid),
		.code_error   (code_error)
	);

endmodule

`default_nettype wire

//--- bench/encoder_8b10b_assert.sv
`timescale 1ns/1ns
`default_nettype none

module encoder_8b10b_assert import line_code_pkg::*; (
	input logic       pclk,
	input logic       reset,
	input logic       enable,
	input logic       tx_data_k,
	input data_byte_t data,
	input symbol_t    symbol,
	input logic       symbol_valid,
	input logic       code_error
);

	int fail_timing = 0;
	int fail_balance = 0;
	int fail_run = 0;
	int fail_comma = 0;
	int fail_error = 0;
	int fail_total;

	logic en_d1;
	logic en_d2;
	logic comma_d1;
	logic comma_d2;
	logic bad_d1;
	logic bad_d2;
	// High when the line disparity is positive
	logic rd_track;
	logic stream_on;
	logic tail_bit;
	int   tail_len;

	// The twelve legal control bytes
	function automatic logic is_legal_k(data_byte_t value);
		return value inside {
			8'h1C, 8'h3C, 8'h5C, 8'h7C, 8'h9C, 8'hBC, 8'hDC, 8'hFC,
			8'hF7, 8'hFB, 8'hFD, 8'hFE
		};
	endfunction

	// Longest run including the tail of the previous symbol
	function automatic int longest_run(logic last_bit, int carry, symbol_t sym);
		int   run;
		int   best;
		logic bit_prev;
		run = carry;
		best = carry;
		bit_prev = last_bit;
		for (int i = symbol_width - 1; i >= 0; i--) begin
			if (run > 0 && sym[i] == bit_prev) begin
				run = run + 1;
			end else begin
				run = 1;
			end
			bit_prev = sym[i];
			if (run > best) begin
				best = run;
			end
		end
		return best;
	endfunction

	function automatic int trailing_run(symbol_t sym);
		int   run;
		logic same;
		run = 0;
		same = 1'b1;
		for (int i = 0; i < symbol_width; i++) begin
			if (same && sym[i] == sym[0]) begin
				run = run + 1;
			end else begin
				same = 1'b0;
			end
		end
		return run;
	endfunction

	always_comb begin
		fail_total = fail_timing + fail_balance + fail_run + fail_comma + fail_error;
	end

	always_ff @(posedge pclk) begin
		if (reset) begin
			en_d1     <= 1'b0;
			en_d2     <= 1'b0;
			comma_d1  <= 1'b0;
			comma_d2  <= 1'b0;
			bad_d1    <= 1'b0;
			bad_d2    <= 1'b0;
			rd_track  <= 1'b0;
			stream_on <= 1'b0;
			tail_bit  <= 1'b0;
			tail_len  <= 0;
		end else begin
			en_d1     <= enable;
			en_d2     <= en_d1;
			comma_d1  <= enable && tx_data_k && (data inside {8'h3C, 8'hBC, 8'hFC});
			comma_d2  <= comma_d1;
			bad_d1    <= enable && tx_data_k && !is_legal_k(data);
			bad_d2    <= bad_d1;
			stream_on <= symbol_valid;
			if (symbol_valid) begin
				tail_bit <= symbol[0];
				tail_len <= trailing_run(symbol);
				if ($countones(symbol) == 6) begin
					rd_track <= 1'b1;
				end else if ($countones(symbol) == 4) begin
					rd_track <= 1'b0;
				end
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Properties
	//////////////////////////////////////////////////////////////////////

	valid_timing: assert property (@(posedge pclk) disable iff (reset)
		symbol_valid == en_d2)
	else begin
		fail_timing = fail_timing + 1;
		$error("symbol_valid does not follow enable by two cycles");
	end

	ones_balance: assert property (@(posedge pclk) disable iff (reset)
		symbol_valid |-> (($countones(symbol) == 5) ||
			($countones(symbol) == 6 && !rd_track) ||
			($countones(symbol) == 4 && rd_track)))
	else begin
		fail_balance = fail_balance + 1;
		$error("symbol ones count breaks running disparity");
	end

	run_length: assert property (@(posedge pclk) disable iff (reset)
		symbol_valid |-> (longest_run(tail_bit, stream_on ? tail_len : 0, symbol) <= run_limit))
	else begin
		fail_run = fail_run + 1;
		$error("run of equal bits longer than the limit");
	end

	comma_place: assert property (@(posedge pclk) disable iff (reset)
		symbol_valid |->
			(((symbol[9:3] == comma_plus) || (symbol[9:3] == comma_minus)) == comma_d2))
	else begin
		fail_comma = fail_comma + 1;
		$error("comma pattern present without a comma byte or missing after one");
	end

	error_flag: assert property (@(posedge pclk) disable iff (reset)
		code_error == bad_d2)
	else begin
		fail_error = fail_error + 1;
		$error("code_error does not match an illegal control byte");
	end

endmodule

bind encoder_8b10b encoder_8b10b_assert checks (.*);

`default_nettype wire

//--- bench/encoder_8b10b_tb.sv
`timescale 1ns/1ns
`default_nettype none

module encoder_8b10b_tb import line_code_pkg::*; ();

	localparam int cycle_limit = 1000;
	localparam int burst_len   = 200;
	localparam int k_repeats   = 3;

	logic       pclk;
	logic       reset;
	logic       enable;
	logic       tx_data_k;
	data_byte_t data;
	symbol_t    symbol;
	logic       symbol_valid;
	logic       code_error;

	logic [31:0] lcg_state;
	int          bytes_sent;
	int          symbols_seen;
	int          mismatches;
	int          cycles;
	int          assert_failures;

	// K28.0 to K28.7, then K23.7, K27.7, K29.7, K30.7
	data_byte_t control_codes [12] = '{
		8'h1C, 8'h3C, 8'h5C, 8'h7C, 8'h9C, 8'hBC, 8'hDC, 8'hFC,
		8'hF7, 8'hFB, 8'hFD, 8'hFE
	};
	data_byte_t bad_codes [6] = '{8'h00, 8'h17, 8'hB5, 8'h7B, 8'hDE, 8'hFF};

	encoder_8b10b dut (
		.pclk         (pclk),
		.reset        (reset),
		.enable       (enable),
		.tx_data_k    (tx_data_k),
		.data         (data),
		.symbol       (symbol),
		.symbol_valid (symbol_valid),
		.code_error   (code_error)
	);

	always #50 pclk = ~pclk;

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic send_byte(input logic k, input data_byte_t value);
		@(posedge pclk);
		enable    <= 1'b1;
		tx_data_k <= k;
		data      <= value;
		bytes_sent = bytes_sent + 1;
	endtask

	task automatic idle_cycles(input int count);
		repeat (count) begin
			@(posedge pclk);
			enable    <= 1'b0;
			tx_data_k <= 1'b0;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Output count and timeout
	//////////////////////////////////////////////////////////////////////

	always @(posedge pclk) begin
		cycles = cycles + 1;
		if (!reset && symbol_valid) begin
			symbols_seen = symbols_seen + 1;
		end
		if (cycles >= cycle_limit) begin
			$display("timeout: run stopped after %0d cycles with %0d of %0d symbols out",
				cycles, symbols_seen, bytes_sent);
			$display("test failed");
			$finish;
		end
	end

	initial begin
		int gap;
		pclk = 1'b0;
		reset = 1'b1;
		enable = 1'b0;
		tx_data_k = 1'b0;
		data = '0;
		lcg_state = 32'h1e85_80d4;
		bytes_sent = 0;
		symbols_seen = 0;
		mismatches = 0;
		cycles = 0;
		assert_failures = 0;

		repeat (2) @(posedge pclk);
		reset <= 1'b0;

		// Every data byte with idle gaps of zero to two cycles
		for (int b = 0; b < 256; b++) begin
			send_byte(1'b0, data_byte_t'(b));
			lcg_state = lcg_next(lcg_state);
			gap = 0;
			if (lcg_state[17]) begin
				gap = 1;
			end
			if (lcg_state[17] && lcg_state[18]) begin
				gap = 2;
			end
			idle_cycles(gap);
		end
		idle_cycles(1);

		// Back-to-back burst
		repeat (burst_len) begin
			lcg_state = lcg_next(lcg_state);
			send_byte(1'b0, lcg_state[31:24]);
		end
		idle_cycles(2);

		repeat (k_repeats) begin
			foreach (control_codes[i]) begin
				send_byte(1'b1, control_codes[i]);
			end
		end
		idle_cycles(1);
		foreach (bad_codes[i]) begin
			send_byte(1'b1, bad_codes[i]);
		end
		idle_cycles(1);

		// Wait for the pipeline to drain
		while (symbols_seen < bytes_sent) begin
			@(posedge pclk);
		end
		idle_cycles(3);

		if (symbols_seen != bytes_sent) begin
			mismatches = mismatches + 1;
			$display("mismatch at %0t: %0d symbols for %0d bytes sent",
				$time, symbols_seen, bytes_sent);
		end
		assert_failures = dut.checks.fail_total;

		$display("errors: %0d count mismatches, %0d assertion failures",
			mismatches, assert_failures);
		if (mismatches == 0 && assert_failures == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- encoder_8b10b.f
hdl/line_code_pkg.sv
hdl/code_group_if.sv
hdl/encode_5b6b.sv
hdl/encode_3b4b.sv
hdl/code_group_decode.sv
hdl/disparity_control.sv
hdl/encoder_8b10b.sv
bench/encoder_8b10b_assert.sv
bench/encoder_8b10b_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the encoder testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module encoder_8b10b_tb \
	-f encoder_8b10b.f -Mdir obj_dir -o sim_encoder \
	|| { echo "build failed"; exit 1; }
./obj_dir/sim_encoder +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log
grep -qx "test passed" sim.log && echo "simulation ok" \
	|| { echo "simulation failed"; exit 1; }
